// File: core_pkg.sv
package core_pkg;

    localparam int rob_width = 4;
    localparam int preg_width = 5;
    localparam int xlen = 32;

    // The wrap bit flips each time the ROB pointer passes the end of the ROB.
    typedef struct packed {
        logic                 dir;
        logic [rob_width-1:0] idx;
    } rob_idx_t;

    typedef logic [preg_width-1:0] preg_t;
    typedef logic [xlen-1:0]       word_t;

    // True when a is strictly older than b.
    function automatic logic rob_older(input rob_idx_t a, input rob_idx_t b);
        logic result;
        if (a.dir == b.dir) begin
            result = a.idx < b.idx;
        end else begin
            result = a.idx > b.idx; // b has wrapped past a.
        end
        return result;
    endfunction

endpackage

// File: csr_pkg.sv
package csr_pkg;

    import core_pkg::*;

    localparam int csr_iq_size = 8;
    localparam int csr_iq_width = 3;

    // Machine CSR addresses held by the CSR unit.
    localparam logic [11:0] csr_mscratch = 12'h340;
    localparam logic [11:0] csr_mtvec = 12'h305;
    localparam logic [11:0] csr_mepc = 12'h341;

    // Values follow the funct3 encoding of the register CSR forms.
    typedef enum logic [2:0] {
        csr_rw = 3'b001,
        csr_rs = 3'b010,
        csr_rc = 3'b011
    } csr_op_t;

    typedef struct packed {
        logic [11:0] csr_addr;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } csr_fields_t;

    // The raw word goes out as trap_inst, the fields are decoded by the CSR unit.
    typedef union packed {
        logic [31:0] raw;
        csr_fields_t fields;
    } csr_inst_u;

    typedef struct packed {
        logic     we;
        preg_t    rs1;
        preg_t    rd;
        rob_idx_t rob_idx;
    } csr_status_t;

    typedef struct packed {
        csr_inst_u   inst;
        csr_status_t status;
        word_t       rdata;
    } csr_issue_t;

endpackage

// File: csr_issue_queue.sv
`timescale 1ns/1ns

module csr_issue_queue import core_pkg::*, csr_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        dis_en,
    input  csr_inst_u   dis_inst,
    input  csr_status_t dis_status,
    output logic        dis_full,
    input  rob_idx_t    commit_rob_idx,
    input  logic        redirect,
    input  rob_idx_t    redirect_idx,
    output preg_t       rd_preg,
    input  word_t       rd_data,
    output logic        issue_en,
    output csr_issue_t  issue,
    output word_t       trap_inst
);

    typedef enum logic {
        st_idle,
        st_writing
    } iq_state_t;

    csr_inst_u   inst_ram [csr_iq_size];
    csr_status_t status_ram [csr_iq_size];
    logic [csr_iq_size-1:0] dir_table;

    iq_state_t state;
    rob_idx_t  write_rob_idx;
    logic [csr_iq_width-1:0] head, tail, head_n, tail_n;
    logic hdir, tdir;
    logic [csr_iq_width:0] occupancy;
    logic enqueue, select_en, issue_q;
    logic keep_any;
    logic [csr_iq_width-1:0] keep_last, keep_next;
    csr_status_t head_status;

    assign occupancy = {tdir, tail} - {hdir, head}; // 0 to csr_iq_size.
    assign dis_full = occupancy[csr_iq_width];
    assign enqueue = dis_en & ~dis_full & ~redirect;
    assign head_n = head + 1'b1;
    assign tail_n = tail + 1'b1;
    assign head_status = status_ram[head];

    // CSR instructions only leave the queue once the ROB is committing them.
    assign select_en = (occupancy != '0) && state == st_idle &&
                       head_status.rob_idx == commit_rob_idx && !redirect;
    assign rd_preg = head_status.rs1;

    // A redirect in the issue cycle kills the instruction unless it is older.
    assign issue_en = issue_q & (~redirect | rob_older(issue.status.rob_idx, redirect_idx));

    always_ff @(posedge clk) begin
        if (enqueue) begin
            inst_ram[tail] <= dis_inst;
            status_ram[tail] <= dis_status;
        end
        if (select_en) begin
            issue.inst <= inst_ram[head];
            issue.status <= head_status;
            issue.rdata <= rd_data;
        end
    end

    // Walk from the head and remember the youngest entry that survives the redirect.
    always_comb begin
        logic [csr_iq_width-1:0] slot;
        keep_any = 1'b0;
        keep_last = head;
        for (int k = 0; k < csr_iq_size; k++) begin
            slot = head + csr_iq_width'(k);
            if ((csr_iq_width+1)'(k) < occupancy &&
                !rob_older(redirect_idx, status_ram[slot].rob_idx)) begin
                keep_any = 1'b1;
                keep_last = slot;
            end
        end
    end
    assign keep_next = keep_last + 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
            write_rob_idx <= '0;
            head <= '0;
            hdir <= 1'b0;
            issue_q <= 1'b0;
            trap_inst <= '0;
        end else begin
            issue_q <= select_en;
            if (select_en) begin
                trap_inst <= inst_ram[head].raw;
            end
            case (state)
                st_idle: begin
                    if (select_en) begin
                        state <= st_writing;
                        write_rob_idx <= head_status.rob_idx;
                    end
                end
                st_writing: begin
                    // The ROB moved on, so the entry has retired.
                    if (write_rob_idx != commit_rob_idx) begin
                        state <= st_idle;
                        head <= head_n;
                        hdir <= (head == '1) ? ~hdir : hdir;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tail <= '0;
            tdir <= 1'b0;
            dir_table <= '0;
        end else if (redirect) begin
            tail <= keep_any ? keep_next : head;
            if (keep_any) begin
                tdir <= (keep_last == '1) ? ~dir_table[keep_last] : dir_table[keep_last];
            end else begin
                tdir <= hdir;
            end
        end else if (enqueue) begin
            tail <= tail_n;
            tdir <= (tail == '1) ? ~tdir : tdir;
            dir_table[tail] <= tdir;
        end
    end

    a_no_enq_full: assert property (@(posedge clk) disable iff (rst)
        occupancy <= csr_iq_size);

    a_one_in_flight: assert property (@(posedge clk) disable iff (rst)
        select_en |=> !select_en [*2]);

endmodule

// File: preg_file.sv
`timescale 1ns/1ns

module preg_file import core_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  preg_t raddr,
    output word_t rdata,
    input  logic  we0,
    input  preg_t waddr0,
    input  word_t wdata0,
    input  logic  we1,
    input  preg_t waddr1,
    input  word_t wdata1
);

    localparam int preg_num = 1 << preg_width;

    word_t regs [preg_num];

    assign rdata = (raddr == '0) ? '0 : regs[raddr]; // Register 0 is hard zero.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < preg_num; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we1 && waddr1 != '0) begin
                regs[waddr1] <= wdata1;
            end
            // Port 0 comes second so the CSR writeback wins a collision.
            if (we0 && waddr0 != '0) begin
                regs[waddr0] <= wdata0;
            end
        end
    end

    a_no_zero_write: assert property (@(posedge clk) disable iff (rst)
        !(we0 && waddr0 == '0) && !(we1 && waddr1 == '0));

endmodule

// File: csr_unit.sv
`timescale 1ns/1ns

module csr_unit import core_pkg::*, csr_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       issue_en,
    input  csr_issue_t issue,
    output logic       wb_en,
    output preg_t      wb_rd,
    output word_t      wb_data,
    output logic       done,
    output rob_idx_t   done_rob_idx
);

    word_t mscratch, mtvec, mepc;
    word_t old_val, new_val;
    logic [11:0] addr;
    csr_op_t op;

    assign addr = issue.inst.fields.csr_addr;
    assign op = csr_op_t'(issue.inst.fields.funct3);

    // Addresses outside the three machine CSRs read as zero.
    always_comb begin
        case (addr)
            csr_mscratch: old_val = mscratch;
            csr_mtvec: old_val = mtvec;
            csr_mepc: old_val = mepc;
            default: old_val = '0;
        endcase
    end

    always_comb begin
        case (op)
            csr_rw: new_val = issue.rdata;
            csr_rs: new_val = old_val | issue.rdata;
            csr_rc: new_val = old_val & ~issue.rdata;
            default: new_val = old_val; // Not a register CSR form.
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mscratch <= '0;
            mtvec <= '0;
            mepc <= '0;
            wb_en <= 1'b0;
            done <= 1'b0;
        end else begin
            wb_en <= issue_en & issue.status.we;
            done <= issue_en;
            if (issue_en) begin
                case (addr)
                    csr_mscratch: mscratch <= new_val;
                    csr_mtvec: mtvec <= new_val;
                    csr_mepc: mepc <= new_val;
                    default: ;
                endcase
            end
        end
    end

    // The old CSR value goes back to rd.
    always_ff @(posedge clk) begin
        if (issue_en) begin
            wb_rd <= issue.status.rd;
            wb_data <= old_val;
            done_rob_idx <= issue.status.rob_idx;
        end
    end

    // CSR instructions reach the unit one at a time.
    a_no_back_to_back: assert property (@(posedge clk) disable iff (rst)
        issue_en |=> !issue_en);

endmodule

// File: csr_subsystem.sv
`timescale 1ns/1ns

module csr_subsystem import core_pkg::*, csr_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        dis_en,
    input  csr_inst_u   dis_inst,
    input  csr_status_t dis_status,
    output logic        dis_full,
    input  rob_idx_t    commit_rob_idx,
    input  logic        redirect,
    input  rob_idx_t    redirect_idx,
    input  logic        ext_we,
    input  preg_t       ext_waddr,
    input  word_t       ext_wdata,
    output logic        wb_en,
    output preg_t       wb_rd,
    output word_t       wb_data,
    output logic        done,
    output rob_idx_t    done_rob_idx,
    output word_t       trap_inst
);

    preg_t      rd_preg;
    word_t      rd_data;
    logic       issue_en;
    csr_issue_t issue;

    csr_issue_queue csr_issue_queue_inst (
        .clk            (clk),
        .rst            (rst),
        .dis_en         (dis_en),
        .dis_inst       (dis_inst),
        .dis_status     (dis_status),
        .dis_full       (dis_full),
        .commit_rob_idx (commit_rob_idx),
        .redirect       (redirect),
        .redirect_idx   (redirect_idx),
        .rd_preg        (rd_preg),
        .rd_data        (rd_data),
        .issue_en       (issue_en),
        .issue          (issue),
        .trap_inst      (trap_inst)
    );

    // Port 0 takes the CSR writeback, port 1 the other units.
    preg_file preg_file_inst (
        .clk    (clk),
        .rst    (rst),
        .raddr  (rd_preg),
        .rdata  (rd_data),
        .we0    (wb_en),
        .waddr0 (wb_rd),
        .wdata0 (wb_data),
        .we1    (ext_we),
        .waddr1 (ext_waddr),
        .wdata1 (ext_wdata)
    );

    csr_unit csr_unit_inst (
        .clk          (clk),
        .rst          (rst),
        .issue_en     (issue_en),
        .issue        (issue),
        .wb_en        (wb_en),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .done         (done),
        .done_rob_idx (done_rob_idx)
    );

endmodule

// File: tb_csr_subsystem.sv
`timescale 1ns/1ns

module tb_csr_subsystem import core_pkg::*, csr_pkg::*; ();

    localparam int num_instr = 200;
    localparam int max_cycles = num_instr * 12 + 1000;

    typedef struct packed {
        csr_inst_u   inst;
        csr_status_t status;
    } entry_t;

    logic        clk, rst;
    logic        dis_en, dis_full, redirect, ext_we, wb_en, done;
    csr_inst_u   dis_inst;
    csr_status_t dis_status;
    rob_idx_t    commit_rob_idx, redirect_idx, done_rob_idx;
    preg_t       ext_waddr, wb_rd;
    word_t       ext_wdata, wb_data, trap_inst;

    entry_t   iq_model [$]; // Dispatched and not yet done, oldest first.
    entry_t   pending;
    word_t    pregs [32];
    word_t    csrs [3];
    rob_idx_t next_idx, hold_idx;
    logic     hold, have_pending;
    int       dispatched, completed, redirects, cycles;

    csr_subsystem csr_subsystem_inst (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > max_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", max_cycles);
            $display("Regression failed");
            $fatal(1);
        end
    end

    function automatic int csr_slot(input logic [11:0] addr);
        case (addr)
            csr_mscratch: return 0;
            csr_mtvec: return 1;
            csr_mepc: return 2;
            default: return -1; // Not implemented, reads as zero.
        endcase
    endfunction

    function automatic rob_idx_t next_rob(input rob_idx_t a);
        return rob_idx_t'({a.dir, a.idx} + 5'd1);
    endfunction

    function automatic entry_t random_entry(input rob_idx_t idx);
        entry_t e;
        e.inst.fields.opcode = 7'h73;
        e.inst.fields.funct3 = 3'($urandom_range(1, 3));
        e.inst.fields.rd = 5'($urandom);
        e.inst.fields.rs1 = 5'($urandom);
        case ($urandom_range(0, 3))
            0: e.inst.fields.csr_addr = csr_mscratch;
            1: e.inst.fields.csr_addr = csr_mtvec;
            2: e.inst.fields.csr_addr = csr_mepc;
            default: e.inst.fields.csr_addr = 12'h7c0;
        endcase
        e.status.we = ($urandom_range(0, 3) != 0);
        e.status.rs1 = 5'($urandom);
        e.status.rd = 5'($urandom_range(1, 31)); // Register 0 is never a destination.
        e.status.rob_idx = idx;
        return e;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    // One clock of the ROB: retire on done, maybe redirect, dispatch, move commit.
    task automatic step_cycle(input int dis_pct, input logic redir_ok);
        entry_t e;
        word_t rs_val, old_val, new_val;
        int p, slot;
        @(negedge clk);
        if (done) begin
            if (iq_model.size() == 0) begin
                $display("Error: done fired while no instruction was outstanding");
                $display("Regression failed");
                $fatal(1);
            end
            e = iq_model.pop_front();
            check_value("done order", e.status.rob_idx, done_rob_idx);
            check_value("done at commit", commit_rob_idx, done_rob_idx);
            rs_val = pregs[e.status.rs1];
            slot = csr_slot(e.inst.fields.csr_addr);
            old_val = (slot < 0) ? '0 : csrs[slot];
            case (csr_op_t'(e.inst.fields.funct3))
                csr_rw: new_val = rs_val;
                csr_rs: new_val = old_val | rs_val;
                default: new_val = old_val & ~rs_val;
            endcase
            check_value("wb_en", e.status.we, wb_en);
            check_value("wb_rd", e.status.rd, wb_rd);
            check_value("wb_data", old_val, wb_data);
            check_value("trap_inst", e.inst.raw, trap_inst);
            if (slot >= 0) csrs[slot] = new_val;
            if (e.status.we) pregs[e.status.rd] = old_val;
            completed++;
        end else begin
            check_value("wb_en without done", 0, wb_en);
        end
        redirect = 1'b0;
        if (redir_ok && !hold && iq_model.size() >= 2 && $urandom_range(0, 29) == 0) begin
            p = $urandom_range(1, iq_model.size() - 1); // The committing entry survives.
            redirect = 1'b1;
            redirect_idx = iq_model[p].status.rob_idx;
            while (iq_model.size() > p + 1) begin
                void'(iq_model.pop_back());
            end
            next_idx = next_rob(redirect_idx);
            have_pending = 1'b0; // A held instruction was on the wrong path.
            redirects++;
        end
        if (!redirect && !have_pending && dispatched < num_instr &&
            $urandom_range(0, 99) < dis_pct) begin
            pending = random_entry(next_idx);
            have_pending = 1'b1;
        end
        dis_en = have_pending;
        dis_inst = pending.inst;
        dis_status = pending.status;
        if (have_pending && !dis_full) begin // dis_full holds until the next edge.
            iq_model.push_back(pending);
            next_idx = next_rob(next_idx);
            dispatched++;
            have_pending = 1'b0;
        end
        if (hold) commit_rob_idx = hold_idx;
        else if (iq_model.size() != 0) commit_rob_idx = iq_model[0].status.rob_idx;
        else commit_rob_idx = next_idx;
    endtask

    initial begin
        void'($urandom(91));
        clk = 1'b0;
        rst = 1'b1;
        dis_en = 1'b0;
        dis_inst = '0;
        dis_status = '0;
        commit_rob_idx = '0;
        redirect = 1'b0;
        redirect_idx = '0;
        ext_we = 1'b0;
        ext_waddr = '0;
        ext_wdata = '0;
        pregs = '{default: '0};
        csrs = '{default: '0};
        pending = '0;
        next_idx = '0;
        hold_idx = '0;
        hold = 1'b0;
        have_pending = 1'b0;
        dispatched = 0;
        completed = 0;
        redirects = 0;
        cycles = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("reset dis_full", 0, dis_full);
        check_value("reset wb_en", 0, wb_en);
        check_value("reset done", 0, done);

        for (int r = 1; r < 32; r++) begin
            @(negedge clk);
            ext_we = 1'b1;
            ext_waddr = preg_t'(r);
            ext_wdata = $urandom();
            pregs[r] = ext_wdata;
        end
        @(negedge clk);
        ext_we = 1'b0;

        // An older non-CSR instruction holds commit, so the queue fills up.
        hold_idx = next_idx;
        next_idx = next_rob(next_idx);
        hold = 1'b1;
        while (iq_model.size() < csr_iq_size) step_cycle(100, 1'b0);
        repeat (4) begin
            step_cycle(100, 1'b0);
            check_value("dis_full when queue full", 1, dis_full);
        end
        hold = 1'b0;

        while (dispatched < num_instr) step_cycle(60, 1'b1);
        while (iq_model.size() != 0 || have_pending) step_cycle(0, 1'b0);
        repeat (4) step_cycle(0, 1'b0);
        $display("%0d instructions completed, %0d redirects", completed, redirects);
        $display("Regression passed");
        $finish;
    end

endmodule

// File: src.f
core_pkg.sv
csr_pkg.sv
csr_issue_queue.sv
preg_file.sv
csr_unit.sv
csr_subsystem.sv
tb_csr_subsystem.sv

// File: run.sh
#!/bin/sh
# Build the CSR subsystem testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_csr_subsystem -f src.f -o sim_csr
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_csr > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Regression failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0
